// ==== compile.f ====
+incdir+include
hdl/cam_reg_pkg.sv
hdl/cam_pix_pkg.sv
hdl/cam_wb_if.sv
hdl/word_fifo.sv
hdl/sccb_master.sv
hdl/cam_ctrl.sv
hdl/cam_data.sv
hdl/camera_top.sv
bench/cam_sensor_model.sv
bench/tb_camera.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_camera -f compile.f \
    && ./obj_dir/Vtb_camera | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    || exit 1

// ==== bench/tb_camera.sv ====
`timescale 1ns/10ps
`include "cam_defines.svh"

module tb_camera;

    localparam logic [31:0] ADR_SCCB   = {24'd0, `CAM_ADR_SCCB};
    localparam logic [31:0] ADR_STATUS = {24'd0, `CAM_ADR_STATUS};
    localparam logic [31:0] ADR_CONFIG = {24'd0, `CAM_ADR_CONFIG};
    localparam logic [31:0] ADR_DATA   = {24'd0, `CAM_ADR_DATA};
    localparam logic [31:0] ADR_INFO   = {24'd0, `CAM_ADR_INFO};

    // Run length in clk cycles
    localparam int SCCB_BUDGET     = 2 * 4 * `CAM_SCCB_DIV * 30;
    // PCLKs for 136 bytes plus 2 per line over 10 lines and 9 per frame over 5 frames
    localparam int FRAME_BUDGET    = 8 * (136 + 2 * 10 + 9 * 5);
    localparam int WATCHDOG_CYCLES = SCCB_BUDGET + FRAME_BUDGET + 3000;

    logic        clk;
    logic        rst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        wb_err_o;
    logic        wb_rty_o;
    logic        pclk;
    logic        vsync;
    logic        href;
    logic [7:0]  d;
    logic        sioc_o;
    logic        siod_o;
    logic        irq_new_frame_o;
    logic        config_finished_o;
    logic        sensor_start;
    logic [7:0]  sensor_lines;
    logic [7:0]  sensor_bytes;
    logic        sensor_busy;

    int checks       = 0;
    int value_errors = 0;
    int other_errors = 0;
    int frames_sent  = 0;
    int byte_idx     = 0;
    int irq_count    = 0;
    int vsync_falls  = 0;
    logic irq_prev   = 1'b0;
    logic vsync_prev = 1'b1;

    // SCCB decoder state
    logic        sccb_active = 1'b0;
    int          sccb_bits   = 0;
    logic [31:0] sccb_shift  = '0;
    logic [26:0] sccb_frames [$];

    camera_top u_dut (
        .clk               (clk),
        .rst_i             (rst_i),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_dat_i          (wb_dat_i),
        .wb_sel_i          (wb_sel_i),
        .wb_dat_o          (wb_dat_o),
        .wb_ack_o          (wb_ack_o),
        .wb_err_o          (wb_err_o),
        .wb_rty_o          (wb_rty_o),
        .pclk_i            (pclk),
        .vsync_i           (vsync),
        .href_i            (href),
        .d_i               (d),
        .sioc_o            (sioc_o),
        .siod_o            (siod_o),
        .irq_new_frame_o   (irq_new_frame_o),
        .config_finished_o (config_finished_o)
    );

    cam_sensor_model u_sensor (
        .clk     (clk),
        .start_i (sensor_start),
        .lines_i (sensor_lines),
        .bytes_i (sensor_bytes),
        .busy_o  (sensor_busy),
        .pclk_o  (pclk),
        .vsync_o (vsync),
        .href_o  (href),
        .d_o     (d)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    ////////////////////
    // Checkers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            value_errors++;
            $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            other_errors++;
            $display("Check failed at %0t ns: %s", $time, what);
        end
    endtask

    // Four recorded bytes with the first byte lowest
    function automatic logic [31:0] sent_word(input int idx);
        return {u_sensor.sent_q[idx+3], u_sensor.sent_q[idx+2],
                u_sensor.sent_q[idx+1], u_sensor.sent_q[idx]};
    endfunction

    ////////////////////
    // Bus and sensor tasks
    ////////////////////

    // One Wishbone classic cycle up to ack or rty
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic retry);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdata;
        wb_sel_i <= 4'hf;
        @(posedge clk);
        while (!wb_ack_o && !wb_rty_o && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        check_true(waited < 20, "bus cycle got neither ack nor rty");
        check_value("wb_err_o", 32'd0, {31'd0, wb_err_o});
        rdata = wb_dat_o;
        retry = wb_rty_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    // DATA reads compared against the sensor's byte record
    task automatic read_words(input int count);
        logic [31:0] rdata;
        logic        retry;
        for (int i = 0; i < count; i++) begin
            bus_cycle(1'b0, ADR_DATA, '0, rdata, retry);
            check_value("wb_rty_o on DATA read", 32'd0, {31'd0, retry});
            check_value("wb_dat_o DATA word", sent_word(byte_idx), rdata);
            byte_idx += 4;
        end
    endtask

    task automatic send_frame(input int lines, input int bytes);
        int waited;
        waited = 0;
        @(posedge clk);
        sensor_start <= 1'b1;
        sensor_lines <= 8'(lines);
        sensor_bytes <= 8'(bytes);
        @(posedge clk);
        sensor_start <= 1'b0;
        @(posedge clk);
        while (sensor_busy && waited < 4000) begin
            @(posedge clk);
            waited++;
        end
        check_true(waited < 4000, "sensor model never finished its frame");
        frames_sent++;
    endtask

    ////////////////////
    // Monitors
    ////////////////////

    // Start is SIOD falling with SIOC high
    always @(negedge siod_o) begin
        if (!rst_i && sioc_o === 1'b1) begin
            sccb_active = 1'b1;
            sccb_bits   = 0;
            sccb_shift  = '0;
        end
    end

    always @(posedge sioc_o) begin
        if (sccb_active) begin
            sccb_shift = {sccb_shift[30:0], siod_o};
            sccb_bits++;
        end
    end

    // Stop is SIOD rising with SIOC high
    always @(posedge siod_o) begin
        if (sccb_active && sioc_o === 1'b1) begin
            sccb_active = 1'b0;
            // Last SIOC rise belongs to the stop condition
            check_value("SCCB SIOC rising edges", 32'd28, sccb_bits);
            sccb_frames.push_back(sccb_shift[27:1]);
        end
    end

    // Interrupt pulses against sensor VSYNC falls
    always @(posedge clk) begin
        irq_prev   <= irq_new_frame_o;
        vsync_prev <= vsync;
        if (!rst_i && irq_new_frame_o) begin
            irq_count <= irq_count + 1;
            check_true(!irq_prev, "irq_new_frame_o stayed high for more than one clk");
        end
        if (!rst_i && vsync_prev && !vsync) begin
            vsync_falls <= vsync_falls + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not complete",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [31:0] rdata;
        logic        retry;
        logic [23:0] cmd;
        int          polls;
        int          irq_before;
        int          falls_before;
        void'($urandom(86));
        clk          = 1'b0;
        rst_i        = 1'b1;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_sel_i     = 4'h0;
        sensor_start = 1'b0;
        sensor_lines = 8'd0;
        sensor_bytes = 8'd0;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);

        // Idle outputs after reset
        check_value("wb_ack_o", 32'd0, {31'd0, wb_ack_o});
        check_value("wb_rty_o", 32'd0, {31'd0, wb_rty_o});
        check_value("irq_new_frame_o", 32'd0, {31'd0, irq_new_frame_o});
        check_value("config_finished_o", 32'd0, {31'd0, config_finished_o});
        check_value("sioc_o", 32'd1, {31'd0, sioc_o});
        check_value("siod_o", 32'd1, {31'd0, siod_o});
        bus_cycle(1'b0, ADR_INFO, '0, rdata, retry);
        check_value("INFO after reset", 32'd0, rdata);

        // SCCB write followed by a write while busy
        cmd = 24'($urandom);
        bus_cycle(1'b1, ADR_SCCB, {8'd0, cmd}, rdata, retry);
        check_value("wb_rty_o on first SCCB write", 32'd0, {31'd0, retry});
        bus_cycle(1'b0, ADR_STATUS, '0, rdata, retry);
        check_value("STATUS busy bit", 32'd1, {31'd0, rdata[0]});
        bus_cycle(1'b1, ADR_SCCB, {8'd0, ~cmd}, rdata, retry);
        check_value("wb_rty_o on SCCB write while busy", 32'd1, {31'd0, retry});
        polls = 0;
        do begin
            bus_cycle(1'b0, ADR_STATUS, '0, rdata, retry);
            polls++;
        end while (rdata[0] && polls < 400);
        check_true(polls < 400, "SCCB engine stayed busy");
        check_value("decoded SCCB transfers", 32'd1, sccb_frames.size());
        if (sccb_frames.size() > 0) begin
            check_value("decoded SCCB bits",
                        {5'd0, cmd[23:16], 1'b1, cmd[15:8], 1'b1, cmd[7:0], 1'b1},
                        {5'd0, sccb_frames[0]});
        end

        // Configuration flag
        bus_cycle(1'b1, ADR_CONFIG, 32'd1, rdata, retry);
        check_value("config_finished_o", 32'd1, {31'd0, config_finished_o});
        bus_cycle(1'b0, ADR_CONFIG, '0, rdata, retry);
        check_value("CONFIG readback", 32'd1, rdata);
        bus_cycle(1'b1, ADR_CONFIG, 32'd0, rdata, retry);
        check_value("config_finished_o", 32'd0, {31'd0, config_finished_o});
        bus_cycle(1'b0, ADR_CONFIG, '0, rdata, retry);
        check_value("CONFIG readback", 32'd0, rdata);

        // One frame of 2 x 16 bytes
        send_frame(2, 16);
        read_words(8);
        bus_cycle(1'b0, ADR_DATA, '0, rdata, retry);
        check_value("wb_rty_o on DATA read when empty", 32'd1, {31'd0, retry});

        // Three short frames
        irq_before   = irq_count;
        falls_before = vsync_falls;
        repeat (3) send_frame(1, 8);
        check_value("irq_new_frame_o pulses per VSYNC fall",
                    vsync_falls - falls_before, irq_count - irq_before);
        check_value("irq_new_frame_o pulses", 32'd3, irq_count - irq_before);
        bus_cycle(1'b0, ADR_INFO, '0, rdata, retry);
        check_value("INFO frame count", frames_sent, {16'd0, rdata[31:16]});
        read_words(6);
        bus_cycle(1'b0, ADR_DATA, '0, rdata, retry);
        check_value("wb_rty_o on DATA read when empty", 32'd1, {31'd0, retry});

        // Overflow with 80 bytes unread
        send_frame(5, 16);
        bus_cycle(1'b0, ADR_INFO, '0, rdata, retry);
        check_value("INFO level", 32'd16, {24'd0, rdata[7:0]});
        check_value("INFO overflow", 32'd1, {31'd0, rdata[8]});
        check_value("INFO frame count", frames_sent, {16'd0, rdata[31:16]});
        read_words(16);
        // Last four words were dropped
        byte_idx += 16;
        bus_cycle(1'b0, ADR_DATA, '0, rdata, retry);
        check_value("wb_rty_o on DATA read when empty", 32'd1, {31'd0, retry});

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/cam_sensor_model.sv ====
`timescale 1ns/10ps

module cam_sensor_model (
    input  logic       clk,
    input  logic       start_i,
    input  logic [7:0] lines_i,
    input  logic [7:0] bytes_i,
    output logic       busy_o,
    output logic       pclk_o,
    output logic       vsync_o,
    output logic       href_o,
    output logic [7:0] d_o
);

    logic [2:0] phase = 3'd0;
    // Every byte put on the pins, in order
    logic [7:0] sent_q [$];

    // PCLK at an eighth of clk
    always @(posedge clk) begin
        phase  <= phase + 3'd1;
        pclk_o <= phase[2];
    end

    // Pins change one clk after PCLK falls, stable long before the rise
    task automatic next_pclk_fall();
        @(negedge pclk_o);
        @(posedge clk);
    endtask

    ////////////////////
    // Frame generator
    ////////////////////

    initial begin
        int         n_lines;
        int         n_bytes;
        logic [7:0] pix;
        pclk_o  = 1'b0;
        vsync_o = 1'b1;
        href_o  = 1'b0;
        d_o     = 8'd0;
        busy_o  = 1'b0;
        forever begin
            @(posedge clk);
            if (start_i) begin
                n_lines = int'(lines_i);
                n_bytes = int'(bytes_i);
                busy_o <= 1'b1;
                next_pclk_fall();
                // Frame opens on VSYNC low
                vsync_o <= 1'b0;
                repeat (2) next_pclk_fall();
                for (int l = 0; l < n_lines; l++) begin
                    for (int b = 0; b < n_bytes; b++) begin
                        next_pclk_fall();
                        pix = 8'($urandom);
                        href_o <= 1'b1;
                        d_o    <= pix;
                        sent_q.push_back(pix);
                    end
                    next_pclk_fall();
                    // Line blanking
                    href_o <= 1'b0;
                    next_pclk_fall();
                end
                repeat (2) next_pclk_fall();
                // VSYNC high between frames
                vsync_o <= 1'b1;
                repeat (4) next_pclk_fall();
                busy_o <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/camera_top.sv ====
`timescale 1ns/10ps
`include "cam_defines.svh"

module camera_top (
    input  logic                     clk,
    input  logic                     rst_i,
    // Wishbone slave
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [`CAM_WB_WIDTH-1:0] wb_adr_i,
    input  logic [`CAM_WB_WIDTH-1:0] wb_dat_i,
    input  logic [3:0]               wb_sel_i,
    output logic [`CAM_WB_WIDTH-1:0] wb_dat_o,
    output logic                     wb_ack_o,
    output logic                     wb_err_o,
    output logic                     wb_rty_o,
    // Sensor pins
    input  logic                     pclk_i,
    input  logic                     vsync_i,
    input  logic                     href_i,
    input  logic [`CAM_D_WIDTH-1:0]  d_i,
    output logic                     sioc_o,
    output logic                     siod_o,
    // Status to the system
    output logic                     irq_new_frame_o,
    output logic                     config_finished_o
);

    cam_wb_if ctrl_bus ();
    cam_wb_if data_bus ();

    ////////////////////
    // Address decode
    ////////////////////

    // adr[7] low selects control half, high selects data half
    assign ctrl_bus.cyc   = wb_cyc_i;
    assign ctrl_bus.stb   = wb_stb_i & ~wb_adr_i[7];
    assign ctrl_bus.we    = wb_we_i;
    assign ctrl_bus.adr   = wb_adr_i;
    assign ctrl_bus.sel   = wb_sel_i;
    assign ctrl_bus.dat_w = wb_dat_i;

    assign data_bus.cyc   = wb_cyc_i;
    assign data_bus.stb   = wb_stb_i & wb_adr_i[7];
    assign data_bus.we    = wb_we_i;
    assign data_bus.adr   = wb_adr_i;
    assign data_bus.sel   = wb_sel_i;
    assign data_bus.dat_w = wb_dat_i;

    // Response mux on the same address bit
    assign wb_ack_o = wb_adr_i[7] ? data_bus.ack   : ctrl_bus.ack;
    assign wb_rty_o = wb_adr_i[7] ? data_bus.rty   : ctrl_bus.rty;
    assign wb_dat_o = wb_adr_i[7] ? data_bus.dat_r : ctrl_bus.dat_r;

    // No error response
    assign wb_err_o = 1'b0;

    ////////////////////
    // Halves
    ////////////////////

    cam_ctrl u_ctrl (
        .clk               (clk),
        .rst_i             (rst_i),
        .bus               (ctrl_bus.slave),
        .sioc_o            (sioc_o),
        .siod_o            (siod_o),
        .config_finished_o (config_finished_o)
    );

    cam_data u_data (
        .clk             (clk),
        .rst_i           (rst_i),
        .bus             (data_bus.slave),
        .pclk_i          (pclk_i),
        .vsync_i         (vsync_i),
        .href_i          (href_i),
        .d_i             (d_i),
        .irq_new_frame_o (irq_new_frame_o)
    );

endmodule

// ==== hdl/cam_data.sv ====
`timescale 1ns/10ps
`include "cam_defines.svh"

module cam_data import cam_pix_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_i,
    cam_wb_if.slave                 bus,
    input  logic                    pclk_i,
    input  logic                    vsync_i,
    input  logic                    href_i,
    input  logic [`CAM_D_WIDTH-1:0] d_i,
    output logic                    irq_new_frame_o
);

    logic [2:0]              pclk_sr;
    logic [2:0]              vsync_sr;
    logic [1:0]              href_sr;
    logic [`CAM_D_WIDTH-1:0] d_meta;
    logic [`CAM_D_WIDTH-1:0] d_sync;
    logic                    pclk_rise;
    logic                    vsync_fall;
    logic                    vsync_rise;
    cap_state_e              cap_state;
    logic [1:0]              byte_cnt;
    pix_word_t               word;
    logic                    push_q;
    logic [15:0]             frame_cnt;
    logic                    overflow;
    logic                    req;
    logic                    rd_data;
    logic                    fifo_pop;
    pix_word_t               fifo_head;
    logic                    fifo_empty;
    logic                    fifo_full;
    logic [7:0]              fifo_level;

    ////////////////////
    // Pin synchronizers
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pclk_sr  <= '0;
            vsync_sr <= '0;
            href_sr  <= '0;
        end else begin
            pclk_sr  <= {pclk_sr[1:0], pclk_i};
            vsync_sr <= {vsync_sr[1:0], vsync_i};
            href_sr  <= {href_sr[0], href_i};
        end
    end

    // Data bus ages together with HREF
    always_ff @(posedge clk) begin
        d_meta <= d_i;
        d_sync <= d_meta;
    end

    assign pclk_rise  = pclk_sr[1] & ~pclk_sr[2];
    assign vsync_fall = ~vsync_sr[1] & vsync_sr[2];
    assign vsync_rise = vsync_sr[1] & ~vsync_sr[2];

    ////////////////////
    // Capture and packing
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cap_state       <= WAIT_FRAME;
            byte_cnt        <= '0;
            push_q          <= 1'b0;
            frame_cnt       <= '0;
            irq_new_frame_o <= 1'b0;
        end else begin
            push_q          <= 1'b0;
            irq_new_frame_o <= 1'b0;
            if (vsync_fall) begin
                // New frame, partial word dropped
                cap_state       <= IN_FRAME;
                byte_cnt        <= '0;
                frame_cnt       <= frame_cnt + 16'd1;
                irq_new_frame_o <= 1'b1;
            end else if (vsync_rise) begin
                cap_state <= WAIT_FRAME;
            end else if (cap_state == IN_FRAME && pclk_rise && href_sr[1]) begin
                byte_cnt <= byte_cnt + 2'd1;
                // Word complete on the fourth byte
                push_q   <= (byte_cnt == 2'd3);
            end
        end
    end

    // First byte lands in bits 7:0
    always_ff @(posedge clk) begin
        if (cap_state == IN_FRAME && pclk_rise && href_sr[1]) begin
            word[`CAM_D_WIDTH*byte_cnt +: `CAM_D_WIDTH] <= d_sync;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            overflow <= 1'b0;
        end else if (push_q && fifo_full) begin
            overflow <= 1'b1;
        end
    end

    ////////////////////
    // Bus side
    ////////////////////

    assign req      = bus.cyc & bus.stb & ~bus.ack & ~bus.rty;
    assign rd_data  = req & ~bus.we & (bus.adr[7:0] == `CAM_ADR_DATA);
    assign fifo_pop = rd_data & ~fifo_empty;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus.ack <= 1'b0;
            bus.rty <= 1'b0;
        end else begin
            // Empty FIFO pushes back with a retry
            bus.ack <= req & ~(rd_data & fifo_empty);
            bus.rty <= rd_data & fifo_empty;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (fifo_pop) begin
                bus.dat_r <= fifo_head;
            end else if (!bus.we && bus.adr[7:0] == `CAM_ADR_INFO) begin
                bus.dat_r <= {frame_cnt, 7'd0, overflow, fifo_level};
            end else begin
                bus.dat_r <= '0;
            end
        end
    end

    word_fifo u_fifo (
        .clk    (clk),
        .rst_i  (rst_i),
        .push_i (push_q),
        .data_i (word),
        .pop_i  (fifo_pop),
        .data_o (fifo_head),
        .empty_o(fifo_empty),
        .full_o (fifo_full),
        .level_o(fifo_level)
    );

endmodule

// ==== hdl/cam_ctrl.sv ====
`timescale 1ns/10ps
`include "cam_defines.svh"

module cam_ctrl import cam_reg_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    cam_wb_if.slave  bus,
    output logic     sioc_o,
    output logic     siod_o,
    output logic     config_finished_o
);

    ctrl_reg_e   reg_sel;
    logic        req;
    logic        sccb_start;
    logic [23:0] sccb_cmd;
    logic        sccb_busy;
    logic        sccb_pending;
    logic        config_flag;

    // New cycle only, response must drop between cycles
    assign req = bus.cyc & bus.stb & ~bus.ack & ~bus.rty;

    // Engine counts as busy in the cycle start is issued
    assign sccb_pending = sccb_busy | sccb_start;

    // Word offset decode
    always_comb begin
        case (bus.adr[7:0])
            `CAM_ADR_SCCB:   reg_sel = SCCB;
            `CAM_ADR_STATUS: reg_sel = STATUS;
            `CAM_ADR_CONFIG: reg_sel = CONFIG;
            default:         reg_sel = NONE;
        endcase
    end

    ////////////////////
    // Handshake and control
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus.ack     <= 1'b0;
            bus.rty     <= 1'b0;
            sccb_start  <= 1'b0;
            config_flag <= 1'b0;
        end else begin
            bus.ack    <= 1'b0;
            bus.rty    <= 1'b0;
            sccb_start <= 1'b0;
            if (req) begin
                if (bus.we && reg_sel == SCCB && sccb_pending) begin
                    // Engine still shifting, try again later
                    bus.rty <= 1'b1;
                end else begin
                    bus.ack <= 1'b1;
                    if (bus.we && reg_sel == SCCB) begin
                        sccb_start <= 1'b1;
                    end
                    if (bus.we && reg_sel == CONFIG && bus.sel[0]) begin
                        config_flag <= bus.dat_w[0];
                    end
                end
            end
        end
    end

    // Read data and command word
    always_ff @(posedge clk) begin
        if (req) begin
            case (reg_sel)
                STATUS:  bus.dat_r <= {31'd0, sccb_busy};
                CONFIG:  bus.dat_r <= {31'd0, config_flag};
                default: bus.dat_r <= '0;
            endcase
            // Device id, sub-address, value
            if (bus.we && reg_sel == SCCB && !sccb_pending) begin
                sccb_cmd <= bus.dat_w[23:0];
            end
        end
    end

    assign config_finished_o = config_flag;

    sccb_master u_sccb (
        .clk    (clk),
        .rst_i  (rst_i),
        .start_i(sccb_start),
        .cmd_i  (sccb_cmd),
        .busy_o (sccb_busy),
        .sioc_o (sioc_o),
        .siod_o (siod_o)
    );

endmodule

// ==== hdl/sccb_master.sv ====
`timescale 1ns/10ps
`include "cam_defines.svh"

module sccb_master import cam_reg_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        start_i,
    input  logic [23:0] cmd_i,
    output logic        busy_o,
    output logic        sioc_o,
    output logic        siod_o
);

    // Three phases of 8 data bits plus a don't-care bit
    localparam int NBITS = 27;
    localparam int DIV   = `CAM_SCCB_DIV;

    sccb_state_e      state;
    logic [7:0]       div_cnt;
    logic [1:0]       quarter;
    logic [4:0]       bit_cnt;
    logic [NBITS-1:0] shift;
    logic             tick;

    // End of a quarter SIOC period
    assign tick = (div_cnt == 8'(DIV - 1));

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state   <= IDLE;
            div_cnt <= '0;
            quarter <= '0;
            bit_cnt <= '0;
        end else if (state == IDLE) begin
            if (start_i) begin
                state   <= START;
                div_cnt <= '0;
                quarter <= '0;
                bit_cnt <= '0;
            end
        end else if (!tick) begin
            div_cnt <= div_cnt + 8'd1;
        end else begin
            div_cnt <= '0;
            quarter <= quarter + 2'd1;
            // Phase changes after the fourth quarter
            if (quarter == 2'd3) begin
                case (state)
                    START: state <= BITS;
                    BITS: begin
                        if (bit_cnt == 5'(NBITS - 1)) begin
                            state <= STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 5'd1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // MSB first, don't-care bits driven high
    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            shift <= {cmd_i[23:16], 1'b1, cmd_i[15:8], 1'b1, cmd_i[7:0], 1'b1};
        end else if (state == BITS && tick && quarter == 2'd3) begin
            shift <= {shift[NBITS-2:0], 1'b0};
        end
    end

    ////////////////////
    // Pin decode
    ////////////////////

    always_comb begin
        sioc_o = 1'b1;
        siod_o = 1'b1;
        case (state)
            // SIOD low while SIOC high, then SIOC low
            START: begin
                siod_o = 1'b0;
                sioc_o = (quarter < 2'd2);
            end
            // Data set in q0 with SIOC low, SIOC high for q1 and q2
            BITS: begin
                siod_o = shift[NBITS-1];
                sioc_o = (quarter == 2'd1) || (quarter == 2'd2);
            end
            // SIOC rises first, SIOD follows
            STOP: begin
                siod_o = (quarter >= 2'd2);
                sioc_o = (quarter != 2'd0);
            end
            default: ;
        endcase
    end

    assign busy_o = (state != IDLE);

endmodule

// ==== hdl/word_fifo.sv ====
`timescale 1ns/10ps
`include "cam_defines.svh"

module word_fifo import cam_pix_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       push_i,
    input  pix_word_t  data_i,
    input  logic       pop_i,
    output pix_word_t  data_o,
    output logic       empty_o,
    output logic       full_o,
    output logic [7:0] level_o
);

    localparam int DEPTH = `CAM_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    pix_word_t     mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    // Push when full is lost
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            empty_o <= 1'b1;
            full_o  <= 1'b0;
        end else begin
            // Pointers wrap naturally, depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count   <= count + 1'b1;
                empty_o <= 1'b0;
                full_o  <= (count == (AW+1)'(DEPTH - 1));
            end else if (do_pop && !do_push) begin
                count   <= count - 1'b1;
                full_o  <= 1'b0;
                empty_o <= (count == (AW+1)'(1));
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // Head word, valid while not empty
    assign data_o  = mem[rd_ptr];
    assign level_o = 8'(count);

endmodule

// ==== hdl/cam_wb_if.sv ====
`timescale 1ns/10ps
`include "cam_defines.svh"

interface cam_wb_if;

    // Request side
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`CAM_WB_WIDTH-1:0] adr;
    logic [3:0]               sel;
    logic [`CAM_WB_WIDTH-1:0] dat_w;
    // Response side
    logic [`CAM_WB_WIDTH-1:0] dat_r;
    logic                     ack;
    logic                     rty;

    // Decoder side
    modport master (
        output cyc, stb, we, adr, sel, dat_w,
        input  dat_r, ack, rty
    );

    // Register block side
    modport slave (
        input  cyc, stb, we, adr, sel, dat_w,
        output dat_r, ack, rty
    );

endinterface

// ==== hdl/cam_pix_pkg.sv ====
`include "cam_defines.svh"

package cam_pix_pkg;

    // Four packed pixel bytes, first byte in bits 7:0
    typedef logic [`CAM_WB_WIDTH-1:0] pix_word_t;

    // Capture FSM
    typedef enum logic [0:0] {
        WAIT_FRAME,
        IN_FRAME
    } cap_state_e;

endpackage

// ==== hdl/cam_reg_pkg.sv ====
`include "cam_defines.svh"

package cam_reg_pkg;

    // Decoded control register, value is its offset
    typedef enum logic [7:0] {
        SCCB   = `CAM_ADR_SCCB,
        STATUS = `CAM_ADR_STATUS,
        CONFIG = `CAM_ADR_CONFIG,
        // Unmapped offset
        NONE   = 8'hff
    } ctrl_reg_e;

    // SCCB write engine phases
    typedef enum logic [1:0] {
        IDLE,
        START,
        BITS,
        STOP
    } sccb_state_e;

endpackage

// ==== include/cam_defines.svh ====
`ifndef CAM_DEFINES_SVH
`define CAM_DEFINES_SVH

////////////////////
// Widths
////////////////////

// System bus data and address width
`define CAM_WB_WIDTH 32
// Sensor parallel data width
`define CAM_D_WIDTH 8

////////////////////
// Sizes and timing
////////////////////

// Pixel word buffer depth, power of two
`define CAM_FIFO_DEPTH 16
// clk cycles per quarter SIOC period
`define CAM_SCCB_DIV 4

////////////////////
// Register map, low address byte
////////////////////

// Control half, adr[7] low
`define CAM_ADR_SCCB   8'h00
`define CAM_ADR_STATUS 8'h04
`define CAM_ADR_CONFIG 8'h08
// Data half, adr[7] high
`define CAM_ADR_DATA   8'h80
`define CAM_ADR_INFO   8'h84

`endif
